// File: fc_layer.f
+incdir+tests
hw/fc_pkg.sv
hw/fc_bias_regs.sv
hw/fc_row_sequencer.sv
hw/fc_neuron_dot.sv
hw/fc_accum_relu.sv
hw/fc_layer_top.sv
tests/tb_fc_layer.sv

// File: hw/fc_accum_relu.sv
/*
 * fc_accum_relu
 * per-neuron row accumulation, bias add on the last row, rectifier and output
 */
`timescale 1ns/1ps

module fc_accum_relu import fc_pkg::*; (
	input  logic        clk,
	input  logic        rst,

	input  row_flags_t  flags,
	input  value_bank_t terms,
	input  value_bank_t biases,

	output logic        out_valid,
	output value_bank_t out_values
);

	value_bank_t acc_q;
	value_bank_t acc_next;
	value_bank_t with_bias;
	value_bank_t relu_out;

	// first row loads and later rows add modulo 2^16
	always_comb begin
		for (int n = 0; n < NUM_NEURONS; n++) begin
			if (flags.first) begin
				acc_next[n] = terms[n];
			end else begin
				acc_next[n] = acc_q[n] + terms[n];
			end
		end
	end

	always_comb begin
		for (int n = 0; n < NUM_NEURONS; n++) begin
			with_bias[n] = acc_next[n] + biases[n];
		end
	end

	// anything above 0x8000 reads as zero while 0x8000 itself passes
	always_comb begin
		for (int n = 0; n < NUM_NEURONS; n++) begin
			if (with_bias[n] > RELU_LIMIT) begin
				relu_out[n] = '0;
			end else begin
				relu_out[n] = with_bias[n];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (flags.valid) begin
			acc_q <= acc_next;
		end
	end

	// held until the next completed vector
	always_ff @(posedge clk) begin
		if (flags.valid && flags.last) begin
			out_values <= relu_out;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= flags.valid && flags.last;
		end
	end

endmodule

// File: hw/fc_bias_regs.sv
/*
 * fc_bias_regs
 * sixteen neuron bias registers, written one at a time by strobe
 */
`timescale 1ns/1ps

module fc_bias_regs import fc_pkg::*; (
	input  logic        clk,
	input  logic        rst,

	input  logic        bias_we,
	input  neuron_idx_t bias_idx,
	input  act_t        bias_data,

	output value_bank_t biases
);

	value_bank_t bias_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			bias_q <= '0;
		end else if (bias_we) begin
			bias_q[bias_idx] <= bias_data;
		end
	end

	// read continuously by the accumulator
	assign biases = bias_q;

endmodule

// File: hw/fc_layer_top.sv
/*
 * fc_layer_top
 * fully connected layer of 16 neurons: row sequencer, dot units,
 * accumulators and the bias block
 */
`timescale 1ns/1ps

module fc_layer_top import fc_pkg::*; #(
	parameter int NUM_ROWS = 28
) (
	input  logic         clk,
	input  logic         rst,

	// one row per strobe
	input  logic         in_valid,
	input  act_row_t     in_row,
	input  weight_bank_t in_weights,

	// bias writes
	input  logic         bias_we,
	input  neuron_idx_t  bias_idx,
	input  act_t         bias_data,

	output logic         out_valid,
	output value_bank_t  out_values
);

	row_flags_t  flags;
	value_bank_t terms;
	value_bank_t biases;

	fc_bias_regs u_bias_regs (
		.clk       (clk),
		.rst       (rst),
		.bias_we   (bias_we),
		.bias_idx  (bias_idx),
		.bias_data (bias_data),
		.biases    (biases)
	);

	fc_row_sequencer #(
		.NUM_ROWS (NUM_ROWS)
	) u_row_sequencer (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.flags    (flags)
	);

	// every neuron's dot unit sees the same row
	for (genvar n = 0; n < NUM_NEURONS; n++) begin : gen_neuron
		fc_neuron_dot u_neuron_dot (
			.clk      (clk),
			.in_valid (in_valid),
			.in_row   (in_row),
			.weights  (in_weights[n]),
			.term     (terms[n])
		);
	end

	fc_accum_relu u_accum_relu (
		.clk        (clk),
		.rst        (rst),
		.flags      (flags),
		.terms      (terms),
		.biases     (biases),
		.out_valid  (out_valid),
		.out_values (out_values)
	);

endmodule

// File: hw/fc_neuron_dot.sv
/*
 * fc_neuron_dot
 * 7-term dot product of one neuron, scaled to a 16-bit term and registered
 */
`timescale 1ns/1ps

module fc_neuron_dot import fc_pkg::*; (
	input  logic     clk,

	input  logic     in_valid,
	input  act_row_t in_row,
	input  act_row_t weights,

	output act_t     term
);

	logic [DOT_W-1:0] prod [ROW_LEN];
	logic [DOT_W-1:0] dot_sum;
	logic [TERM_W-1:0] scaled;

	// each 16x16 product fits 32 bits
	always_comb begin
		for (int i = 0; i < ROW_LEN; i++) begin
			prod[i] = DOT_W'(in_row.data[i]) * DOT_W'(weights.data[i]);
		end
	end

	// sum wraps at 2^32
	always_comb begin
		dot_sum = '0;
		for (int i = 0; i < ROW_LEN; i++) begin
			dot_sum = dot_sum + prod[i];
		end
	end

	// drop the fraction bits, keep up to bit 24
	assign scaled = dot_sum[TERM_TOP:FRAC_SHIFT];

	always_ff @(posedge clk) begin
		if (in_valid) begin
			term <= {{(ACT_W - TERM_W){1'b0}}, scaled};
		end
	end

endmodule

// File: hw/fc_pkg.sv
/*
 * fc_layer shared definitions
 * data widths, layer sizes and the packed types used between blocks
 */
package fc_pkg;

	// unsigned fixed point with 10 fraction bits
	localparam int ACT_W = 16;
	localparam int ROW_LEN = 7;
	localparam int NUM_NEURONS = 16;
	localparam int IDX_W = $clog2(NUM_NEURONS);

	// full dot product width kept modulo 2^32
	localparam int DOT_W = 32;

	// scaling window taken out of the dot sum
	localparam int FRAC_SHIFT = 10;
	localparam int TERM_TOP = 24;
	localparam int TERM_W = TERM_TOP - FRAC_SHIFT + 1;

	typedef logic [ACT_W-1:0] act_t;

	// values above this are clamped to zero
	localparam act_t RELU_LIMIT = 16'h8000;

	// one input row with element 0 in the low word
	typedef struct packed {
		act_t [ROW_LEN-1:0] data;
	} act_row_t;

	// row weights for every neuron with neuron 0 in the low slice
	typedef act_row_t [NUM_NEURONS-1:0] weight_bank_t;

	// one word per neuron
	typedef act_t [NUM_NEURONS-1:0] value_bank_t;

	typedef logic [IDX_W-1:0] neuron_idx_t;

	// position of the row currently in the term stage
	typedef struct packed {
		logic valid;
		logic first;
		logic last;
	} row_flags_t;

endpackage

// File: hw/fc_row_sequencer.sv
/*
 * fc_row_sequencer
 * counts rows within a vector and flags the first and last row of each one
 */
`timescale 1ns/1ps

module fc_row_sequencer import fc_pkg::*; #(
	parameter int NUM_ROWS = 28
) (
	input  logic       clk,
	input  logic       rst,

	input  logic       in_valid,

	output row_flags_t flags
);

	// keep at least one bit for a single-row vector
	localparam int CNT_W = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1;
	localparam logic [CNT_W-1:0] LAST_ROW = CNT_W'(NUM_ROWS - 1);

	logic [CNT_W-1:0] row_cnt;
	logic             at_first;
	logic             at_last;

	assign at_first = (row_cnt == '0);
	assign at_last = (row_cnt == LAST_ROW);

	always_ff @(posedge clk) begin
		if (rst) begin
			row_cnt <= '0;
		end else if (in_valid) begin
			if (at_last) begin
				row_cnt <= '0;
			end else begin
				row_cnt <= row_cnt + 1'b1;
			end
		end
	end

	// registered on the dot-term edge so flags and terms stay aligned
	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
		end else begin
			flags.valid <= in_valid;
			flags.first <= in_valid && at_first;
			flags.last <= in_valid && at_last;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the fc_layer testbench with Verilator.
# Exit status is 0 on pass, 1 on any failure.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_fc_layer

verilator --binary --timing --assert \
	-f fc_layer.f \
	--top-module "$TOP" \
	-Mdir "$BUILD_DIR" \
	-o "$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	echo "simulation reported failure, see $LOG"
	exit 1
fi

echo "simulation passed"
exit 0

// File: tests/tb_fc_model.svh
/*
 * reference model of the fc layer, LFSR random source and expected-bank queue
 */
`ifndef TB_FC_MODEL_SVH
`define TB_FC_MODEL_SVH

	// fibonacci LFSR with taps 32 22 2 1
	logic [31:0] lfsr_state = 32'he657;

	// one model accumulator per neuron
	act_t exp_acc [NUM_NEURONS];
	value_bank_t bias_shadow = '0;
	int row_pos = 0;
	value_bank_t exp_q[$];
	int stamp_q[$];

	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	// dot sum kept modulo 2^32, then bits 24..10 zero-extended
	function automatic act_t term_ref(input act_row_t row, input act_row_t w);
		longint unsigned acc;
		logic [31:0] sum32;
		acc = 0;
		for (int i = 0; i < ROW_LEN; i++) begin
			acc = acc + longint'(row.data[i]) * longint'(w.data[i]);
		end
		sum32 = acc[31:0];
		return act_t'({1'b0, sum32[TERM_TOP:FRAC_SHIFT]});
	endfunction

	// only values strictly above 0x8000 are cleared
	function automatic act_t relu_ref(input act_t v);
		if (v > 16'h8000) begin
			return '0;
		end
		return v;
	endfunction

	function automatic void model_row(input act_row_t row, input weight_bank_t w);
		value_bank_t done;
		act_t sum;
		for (int n = 0; n < NUM_NEURONS; n++) begin
			if (row_pos == 0) begin
				exp_acc[n] = term_ref(row, w[n]);
			end else begin
				exp_acc[n] = exp_acc[n] + term_ref(row, w[n]);
			end
		end
		if (row_pos == NUM_ROWS - 1) begin
			for (int n = 0; n < NUM_NEURONS; n++) begin
				sum = exp_acc[n] + bias_shadow[n];
				done[n] = relu_ref(sum);
			end
			exp_q.push_back(done);
			row_pos = 0;
		end else begin
			row_pos++;
		end
	endfunction

`endif

// File: tests/tb_fc_layer.sv
/*
 * testbench for fc_layer_top
 * random rows and biases checked against the model in tb_fc_model.svh
 */
`timescale 1ns/1ps

module tb_fc_layer import fc_pkg::*; ;

	localparam int NUM_ROWS = 4;
	localparam int DRAIN_LIMIT = 200;

	logic         clk;
	logic         rst;
	logic         in_valid;
	act_row_t     in_row;
	weight_bank_t in_weights;
	logic         bias_we;
	neuron_idx_t  bias_idx;
	act_t         bias_data;
	logic         out_valid;
	value_bank_t  out_values;

	int cyc = 0;
	int value_errors = 0;
	int latency_errors = 0;
	int protocol_errors = 0;
	logic prev_valid = 1'b0;
	bit drain_timeout = 1'b0;

	`include "tb_fc_model.svh"

	fc_layer_top #(
		.NUM_ROWS (NUM_ROWS)
	) UUT (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_row     (in_row),
		.in_weights (in_weights),
		.bias_we    (bias_we),
		.bias_idx   (bias_idx),
		.bias_data  (bias_data),
		.out_valid  (out_valid),
		.out_values (out_values)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	task automatic report_and_finish();
		int total;
		total = value_errors + latency_errors + protocol_errors;
		$display("errors: value %0d, latency %0d, protocol %0d, total %0d",
			value_errors, latency_errors, protocol_errors, total);
		if (total == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
			bias_we <= 1'b0;
		end
	endtask

	task automatic send_row(input bit zero_w);
		act_row_t row;
		weight_bank_t w;
		for (int i = 0; i < ROW_LEN; i++) begin
			row.data[i] = act_t'(rand_bits(16));
		end
		for (int n = 0; n < NUM_NEURONS; n++) begin
			for (int i = 0; i < ROW_LEN; i++) begin
				w[n].data[i] = zero_w ? '0 : act_t'(rand_bits(16));
			end
		end
		@(posedge clk);
		in_valid <= 1'b1;
		in_row <= row;
		in_weights <= w;
		bias_we <= 1'b0;
		// cycle count after this edge feeds the latency check
		if (row_pos == NUM_ROWS - 1) begin
			stamp_q.push_back(cyc + 1);
		end
		model_row(row, w);
	endtask

	task automatic send_vector(input int gap_max);
		int gap;
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (gap_max > 0) begin
				gap = int'(rand_bits(2)) % (gap_max + 1);
				idle_cycles(gap);
			end
			send_row(1'b0);
		end
	endtask

	task automatic send_zero_vector();
		for (int r = 0; r < NUM_ROWS; r++) begin
			send_row(1'b1);
		end
	endtask

	task automatic write_bias(input int idx, input act_t val);
		@(posedge clk);
		in_valid <= 1'b0;
		bias_we <= 1'b1;
		bias_idx <= neuron_idx_t'(idx);
		bias_data <= val;
		bias_shadow[idx] = val;
	endtask

	task automatic write_random_biases();
		for (int n = 0; n < NUM_NEURONS; n++) begin
			write_bias(n, act_t'(rand_bits(16)));
		end
	endtask

	task automatic wait_drained();
		int waited;
		@(posedge clk);
		in_valid <= 1'b0;
		bias_we <= 1'b0;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			protocol_errors++;
			$display("timeout at %0t: %0d result banks never came out", $time, exp_q.size());
			drain_timeout = 1'b1;
		end
	endtask

	// outputs settle after the rising edge, so compare on the falling one
	always @(negedge clk) begin : check_outputs
		value_bank_t exp_bank;
		int stamp;
		if (!rst) begin
			if (out_valid) begin
				assert (!prev_valid) else begin
					protocol_errors++;
					$display("out_valid stayed high for more than one cycle at %0t", $time);
				end
				assert (exp_q.size() != 0) else begin
					protocol_errors++;
					$display("out_valid pulsed with no vector outstanding at %0t", $time);
				end
				if (exp_q.size() != 0) begin
					exp_bank = exp_q.pop_front();
					stamp = stamp_q.pop_front();
					for (int n = 0; n < NUM_NEURONS; n++) begin
						assert (out_values[n] == exp_bank[n]) else begin
							value_errors++;
							$display("FAILED t=%0t out_values[%0d] got %h expected %h",
								$time, n, out_values[n], exp_bank[n]);
						end
					end
					assert (cyc - stamp == 2) else begin
						latency_errors++;
						$display("FAILED t=%0t out_valid latency got %0d expected 2",
							$time, cyc - stamp);
					end
				end
			end
			prev_valid = out_valid;
		end
	end

	task automatic run_phases();
		// quiet after reset, then an all-zero vector
		idle_cycles(8);
		send_zero_vector();
		wait_drained();
		if (drain_timeout) begin
			return;
		end

		// back-to-back random vectors
		write_random_biases();
		for (int v = 0; v < 6; v++) begin
			send_vector(0);
		end
		wait_drained();
		if (drain_timeout) begin
			return;
		end

		// rectifier edges around 0x8000
		for (int n = 0; n < NUM_NEURONS; n++) begin
			case (n % 4)
				0: write_bias(n, 16'h8000);
				1: write_bias(n, 16'h8001);
				2: write_bias(n, 16'h7fff);
				default: write_bias(n, 16'hffff);
			endcase
		end
		send_zero_vector();
		wait_drained();
		if (drain_timeout) begin
			return;
		end

		// idle gaps between rows
		write_random_biases();
		for (int v = 0; v < 6; v++) begin
			send_vector(3);
		end
		wait_drained();
		if (drain_timeout) begin
			return;
		end

		// bias rewrite lands between two vectors in flight
		send_vector(0);
		write_bias(3, act_t'(rand_bits(16)));
		write_bias(9, act_t'(rand_bits(16)));
		send_vector(0);
		wait_drained();
		if (drain_timeout) begin
			return;
		end

		// mixed traffic
		for (int v = 0; v < 16; v++) begin
			if (rand_bits(2) == 0) begin
				write_bias(int'(rand_bits(4)), act_t'(rand_bits(16)));
			end
			send_vector(int'(rand_bits(2)) % 3);
		end
		wait_drained();
		if (drain_timeout) begin
			return;
		end

		idle_cycles(4);
	endtask

	initial begin
		rst <= 1'b1;
		in_valid <= 1'b0;
		in_row <= '0;
		in_weights <= '0;
		bias_we <= 1'b0;
		bias_idx <= '0;
		bias_data <= '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		run_phases();
		report_and_finish();
	end

endmodule
